// ==== rtl/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath sizing shared by packages and RTL

`define EXEC_XLEN     32    // One machine word
`define EXEC_SHAMT_W  5     // Shift amount field
`define EXEC_IMM_W    16    // I-format immediate field

// Word holds exactly 2^SHAMT_W bit positions
// so a shift amount never exceeds the word

`endif

// ==== rtl/mips_isa_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package mips_isa_pkg;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        opc_special = 6'h00,    // R-format, decode funct
        opc_regimm  = 6'h01,    // Only bltz (rt == 0)
        opc_beq     = 6'h04,
        opc_bne     = 6'h05,
        opc_blez    = 6'h06,
        opc_bgtz    = 6'h07,
        opc_addi    = 6'h08,
        opc_addiu   = 6'h09,
        opc_slti    = 6'h0a,
        opc_sltiu   = 6'h0b,
        opc_andi    = 6'h0c,
        opc_ori     = 6'h0d,
        opc_xori    = 6'h0e
    } opcode_e;

    // Function field of R-format, bits 5:0
    typedef enum logic [5:0] {
        fn_sll   = 6'd0,  fn_srl   = 6'd2,  fn_sra   = 6'd3,
        fn_sllv  = 6'd4,  fn_srlv  = 6'd6,  fn_srav  = 6'd7,
        fn_mfhi  = 6'd16, fn_mthi  = 6'd17, fn_mflo  = 6'd18, fn_mtlo  = 6'd19,
        fn_mult  = 6'd24, fn_multu = 6'd25, fn_div   = 6'd26, fn_divu  = 6'd27,
        fn_add   = 6'd32, fn_addu  = 6'd33, fn_sub   = 6'd34, fn_subu  = 6'd35,
        fn_and   = 6'd36, fn_or    = 6'd37, fn_xor   = 6'd38, fn_nor   = 6'd39,
        fn_slt   = 6'd42, fn_sltu  = 6'd43
    } funct_e;

    typedef struct packed {
        opcode_e                  opcode;   // Always opc_special here
        logic [4:0]               rs;       // Source, feeds op1
        logic [4:0]               rt;       // Source, feeds op2
        logic [4:0]               rd;       // Destination, unused in execute
        logic [`EXEC_SHAMT_W-1:0] shamt;    // Constant shift count
        funct_e                   funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [4:0]             rs;
        logic [4:0]             rt;         // Also the regimm sub-code
        logic [`EXEC_IMM_W-1:0] imm;        // Raw immediate
    } i_fmt_t;

    // Same 32 bits seen two ways, chosen by opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

    // Internal operation, one per supported instruction
    typedef enum logic [5:0] {
        op_sll,  op_srl,   op_sra,   op_sllv,  op_srlv,  op_srav,   // Shifts
        op_mfhi, op_mthi,  op_mflo,  op_mtlo,                       // HI/LO moves
        op_mult, op_multu, op_div,   op_divu,                       // HI/LO writers
        op_add,  op_addu,  op_sub,   op_subu,
        op_and,  op_or,    op_xor,   op_nor,
        op_slt,  op_sltu,
        op_beq,  op_bne,   op_bltz,  op_blez,  op_bgtz,             // Branch compares
        op_addi, op_addiu, op_slti,  op_sltiu,
        op_andi, op_ori,   op_xori,
        op_illegal                                                  // Unknown encoding
    } alu_op_e;

    // Decoder to ALU control bundle
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [`EXEC_SHAMT_W-1:0] shamt;    // From the R-format view
        logic [`EXEC_XLEN-1:0]    imm_ext;  // Sign or zero extended
        logic                     use_imm;  // Second operand is imm_ext
    } exec_ctrl_t;

    // ALU result with its flags
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] result;
        logic                  z_flag;      // Result is zero
        logic                  c_flag;      // Carry or borrow, unsigned forms
        logic                  o_flag;      // Signed overflow
        logic                  b_flag;      // Branch taken
        logic                  illegal;     // Unknown opcode or funct
    } exec_result_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module instr_decode (
    input  mips_isa_pkg::instr_u   instr,
    output exec_pkg::exec_ctrl_t   ctrl
);

    logic [`EXEC_XLEN-1:0] imm_sext;    // Arithmetic and compare forms
    logic [`EXEC_XLEN-1:0] imm_zext;    // Logic forms

    assign imm_sext = {{(`EXEC_XLEN-`EXEC_IMM_W){instr.i.imm[`EXEC_IMM_W-1]}}, instr.i.imm};
    assign imm_zext = {{(`EXEC_XLEN-`EXEC_IMM_W){1'b0}}, instr.i.imm};

    always_comb begin
        ctrl.alu_op  = exec_pkg::op_illegal;    // Anything unmatched
        ctrl.shamt   = instr.r.shamt;
        ctrl.imm_ext = imm_sext;
        ctrl.use_imm = 1'b0;
        if (instr.r.opcode == mips_isa_pkg::opc_special) begin    // R-format view
            case (instr.r.funct)
                mips_isa_pkg::fn_sll:   ctrl.alu_op = exec_pkg::op_sll;
                mips_isa_pkg::fn_srl:   ctrl.alu_op = exec_pkg::op_srl;
                mips_isa_pkg::fn_sra:   ctrl.alu_op = exec_pkg::op_sra;
                mips_isa_pkg::fn_sllv:  ctrl.alu_op = exec_pkg::op_sllv;
                mips_isa_pkg::fn_srlv:  ctrl.alu_op = exec_pkg::op_srlv;
                mips_isa_pkg::fn_srav:  ctrl.alu_op = exec_pkg::op_srav;
                mips_isa_pkg::fn_mfhi:  ctrl.alu_op = exec_pkg::op_mfhi;
                mips_isa_pkg::fn_mthi:  ctrl.alu_op = exec_pkg::op_mthi;
                mips_isa_pkg::fn_mflo:  ctrl.alu_op = exec_pkg::op_mflo;
                mips_isa_pkg::fn_mtlo:  ctrl.alu_op = exec_pkg::op_mtlo;
                mips_isa_pkg::fn_mult:  ctrl.alu_op = exec_pkg::op_mult;
                mips_isa_pkg::fn_multu: ctrl.alu_op = exec_pkg::op_multu;
                mips_isa_pkg::fn_div:   ctrl.alu_op = exec_pkg::op_div;
                mips_isa_pkg::fn_divu:  ctrl.alu_op = exec_pkg::op_divu;
                mips_isa_pkg::fn_add:   ctrl.alu_op = exec_pkg::op_add;
                mips_isa_pkg::fn_addu:  ctrl.alu_op = exec_pkg::op_addu;
                mips_isa_pkg::fn_sub:   ctrl.alu_op = exec_pkg::op_sub;
                mips_isa_pkg::fn_subu:  ctrl.alu_op = exec_pkg::op_subu;
                mips_isa_pkg::fn_and:   ctrl.alu_op = exec_pkg::op_and;
                mips_isa_pkg::fn_or:    ctrl.alu_op = exec_pkg::op_or;
                mips_isa_pkg::fn_xor:   ctrl.alu_op = exec_pkg::op_xor;
                mips_isa_pkg::fn_nor:   ctrl.alu_op = exec_pkg::op_nor;
                mips_isa_pkg::fn_slt:   ctrl.alu_op = exec_pkg::op_slt;
                mips_isa_pkg::fn_sltu:  ctrl.alu_op = exec_pkg::op_sltu;
                default:                ctrl.alu_op = exec_pkg::op_illegal;
            endcase
        end else begin                                              // I-format view
            case (instr.i.opcode)
                mips_isa_pkg::opc_regimm: begin
                    if (instr.i.rt == 5'd0) begin                   // bgez and links unsupported
                        ctrl.alu_op = exec_pkg::op_bltz;
                    end
                end
                mips_isa_pkg::opc_beq:  ctrl.alu_op = exec_pkg::op_beq;
                mips_isa_pkg::opc_bne:  ctrl.alu_op = exec_pkg::op_bne;
                mips_isa_pkg::opc_blez: ctrl.alu_op = exec_pkg::op_blez;
                mips_isa_pkg::opc_bgtz: ctrl.alu_op = exec_pkg::op_bgtz;
                mips_isa_pkg::opc_addi: begin
                    ctrl.alu_op  = exec_pkg::op_addi;
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_addiu: begin
                    ctrl.alu_op  = exec_pkg::op_addiu;
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_slti: begin
                    ctrl.alu_op  = exec_pkg::op_slti;
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_sltiu: begin
                    ctrl.alu_op  = exec_pkg::op_sltiu;      // Sign extend, then compare unsigned
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_andi: begin
                    ctrl.alu_op  = exec_pkg::op_andi;
                    ctrl.imm_ext = imm_zext;
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_ori: begin
                    ctrl.alu_op  = exec_pkg::op_ori;
                    ctrl.imm_ext = imm_zext;
                    ctrl.use_imm = 1'b1;
                end
                mips_isa_pkg::opc_xori: begin
                    ctrl.alu_op  = exec_pkg::op_xori;
                    ctrl.imm_ext = imm_zext;
                    ctrl.use_imm = 1'b1;
                end
                default: ctrl.alu_op = exec_pkg::op_illegal;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module alu (
    input  exec_pkg::exec_ctrl_t    ctrl,
    input  logic [`EXEC_XLEN-1:0]   op1,        // rs value
    input  logic [`EXEC_XLEN-1:0]   op2,        // rt value
    input  logic [`EXEC_XLEN-1:0]   hi,
    input  logic [`EXEC_XLEN-1:0]   lo,
    output exec_pkg::exec_result_t  res,
    output logic                    wr_hilo     // HI/LO write request
);

    localparam int MSB = `EXEC_XLEN - 1;

    logic [`EXEC_XLEN-1:0]    opb;              // rt or extended immediate
    logic [`EXEC_XLEN:0]      sum_ext;          // Extra bit holds carry
    logic [`EXEC_XLEN:0]      diff_ext;         // Extra bit holds borrow
    logic [`EXEC_SHAMT_W-1:0] var_sh;
    logic                     add_ovf;
    logic                     sub_ovf;
    logic                     lt_s;
    logic                     lt_u;

    assign opb      = ctrl.use_imm ? ctrl.imm_ext : op2;
    assign sum_ext  = {1'b0, op1} + {1'b0, opb};
    assign diff_ext = {1'b0, op1} - {1'b0, opb};
    assign var_sh   = op1[`EXEC_SHAMT_W-1:0];   // Low bits of rs only
    assign add_ovf  = (op1[MSB] == opb[MSB]) && (sum_ext[MSB] != op1[MSB]);
    assign sub_ovf  = (op1[MSB] != opb[MSB]) && (diff_ext[MSB] != op1[MSB]);
    assign lt_s     = $signed(op1) < $signed(opb);
    assign lt_u     = op1 < opb;

    always_comb begin
        res.result  = '0;       // Branches, HI/LO writers and illegal give zero
        res.c_flag  = 1'b0;
        res.o_flag  = 1'b0;
        res.b_flag  = 1'b0;
        res.illegal = 1'b0;
        wr_hilo     = 1'b0;
        case (ctrl.alu_op)
            exec_pkg::op_sll:  res.result = op2 << ctrl.shamt;
            exec_pkg::op_srl:  res.result = op2 >> ctrl.shamt;
            exec_pkg::op_sra:  res.result = $signed(op2) >>> ctrl.shamt;
            exec_pkg::op_sllv: res.result = op2 << var_sh;
            exec_pkg::op_srlv: res.result = op2 >> var_sh;
            exec_pkg::op_srav: res.result = $signed(op2) >>> var_sh;
            exec_pkg::op_mfhi: res.result = hi;
            exec_pkg::op_mflo: res.result = lo;
            exec_pkg::op_mthi, exec_pkg::op_mtlo,
            exec_pkg::op_mult, exec_pkg::op_multu,
            exec_pkg::op_div,  exec_pkg::op_divu: wr_hilo = 1'b1;  // Work done in hilo_unit
            exec_pkg::op_add, exec_pkg::op_addi: begin
                res.result = sum_ext[MSB:0];
                res.o_flag = add_ovf;
            end
            exec_pkg::op_addu, exec_pkg::op_addiu: begin
                res.result = sum_ext[MSB:0];
                res.c_flag = sum_ext[`EXEC_XLEN];
            end
            exec_pkg::op_sub: begin
                res.result = diff_ext[MSB:0];
                res.o_flag = sub_ovf;
            end
            exec_pkg::op_subu: begin
                res.result = diff_ext[MSB:0];
                res.c_flag = diff_ext[`EXEC_XLEN];      // Borrow when op1 < op2
            end
            exec_pkg::op_and, exec_pkg::op_andi: res.result = op1 & opb;
            exec_pkg::op_or,  exec_pkg::op_ori:  res.result = op1 | opb;
            exec_pkg::op_xor, exec_pkg::op_xori: res.result = op1 ^ opb;
            exec_pkg::op_nor:                    res.result = ~(op1 | op2);
            exec_pkg::op_slt,  exec_pkg::op_slti:  res.result = {{MSB{1'b0}}, lt_s};
            exec_pkg::op_sltu, exec_pkg::op_sltiu: res.result = {{MSB{1'b0}}, lt_u};
            exec_pkg::op_beq:  res.b_flag = (op1 == op2);
            exec_pkg::op_bne:  res.b_flag = (op1 != op2);
            exec_pkg::op_bltz: res.b_flag = op1[MSB];
            exec_pkg::op_blez: res.b_flag = op1[MSB] || (op1 == '0);
            exec_pkg::op_bgtz: res.b_flag = !op1[MSB] && (op1 != '0);
            default:           res.illegal = 1'b1;     // op_illegal lands here
        endcase
        res.z_flag = (res.result == '0);
    end

endmodule

`default_nettype wire

// ==== rtl/hilo_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module hilo_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr,          // Already qualified by in_valid
    input  exec_pkg::alu_op_e      alu_op,
    input  logic [`EXEC_XLEN-1:0]  op1,
    input  logic [`EXEC_XLEN-1:0]  op2,
    output logic [`EXEC_XLEN-1:0]  hi,          // Read port for mfhi
    output logic [`EXEC_XLEN-1:0]  lo           // Read port for mflo
);

    logic [2*`EXEC_XLEN-1:0] prod_s;
    logic [2*`EXEC_XLEN-1:0] prod_u;
    logic [`EXEC_XLEN-1:0]   quo_s;
    logic [`EXEC_XLEN-1:0]   rem_s;
    logic [`EXEC_XLEN-1:0]   quo_u;
    logic [`EXEC_XLEN-1:0]   rem_u;
    logic                    div_zero;

    assign prod_s   = $signed(op1) * $signed(op2);      // Operands sign extend to 64
    assign prod_u   = {{`EXEC_XLEN{1'b0}}, op1} * {{`EXEC_XLEN{1'b0}}, op2};
    assign quo_s    = $signed(op1) / $signed(op2);
    assign rem_s    = $signed(op1) % $signed(op2);      // Sign follows dividend
    assign quo_u    = op1 / op2;
    assign rem_u    = op1 % op2;
    assign div_zero = (op2 == '0);

    // Single-cycle write, visible to the next instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (wr) begin
            case (alu_op)
                exec_pkg::op_mult:  {hi, lo} <= prod_s;
                exec_pkg::op_multu: {hi, lo} <= prod_u;
                exec_pkg::op_div: begin
                    hi <= div_zero ? op1 : rem_s;   // Divide by zero keeps dividend
                    lo <= div_zero ? '1  : quo_s;   // All ones quotient
                end
                exec_pkg::op_divu: begin
                    hi <= div_zero ? op1 : rem_u;
                    lo <= div_zero ? '1  : quo_u;
                end
                exec_pkg::op_mthi:  hi <= op1;
                exec_pkg::op_mtlo:  lo <= op1;
                default: ;                          // No other op raises wr
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,   // One instruction per strobe
    input  mips_isa_pkg::instr_u    instr,
    input  logic [`EXEC_XLEN-1:0]   op1,        // rs value
    input  logic [`EXEC_XLEN-1:0]   op2,        // rt value
    output logic                    out_valid,  // in_valid one cycle later
    output exec_pkg::exec_result_t  out
);

    exec_pkg::exec_ctrl_t   ctrl;
    exec_pkg::exec_result_t alu_res;
    logic                   alu_wr_hilo;
    logic                   hilo_wr;
    logic [`EXEC_XLEN-1:0]  hi;
    logic [`EXEC_XLEN-1:0]  lo;

    assign hilo_wr = in_valid && alu_wr_hilo;   // No HI/LO change on idle cycles

    instr_decode u_decode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    alu u_alu (
        .ctrl    (ctrl),
        .op1     (op1),
        .op2     (op2),
        .hi      (hi),
        .lo      (lo),
        .res     (alu_res),
        .wr_hilo (alu_wr_hilo)
    );

    hilo_unit u_hilo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (hilo_wr),
        .alu_op (ctrl.alu_op),
        .op1    (op1),
        .op2    (op2),
        .hi     (hi),
        .lo     (lo)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= alu_res;     // Result held until the next valid input
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // Free running
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                          // Released on a rising edge
    end

endmodule

`default_nettype wire

// ==== testbench/exec_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input exec_pkg::exec_result_t out
);

    int fail_count = 0;     // Failed checks so far

    valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid was high after a reset cycle");
            fail_count++;
        end

    // One-cycle latency, no stalls
    valid_follows_input: assert property (@(posedge clk) rst_n |=> (out_valid == $past(in_valid)))
        else begin
            $error("out_valid does not follow in_valid by one cycle");
            fail_count++;
        end

    zero_flag_matches: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out.z_flag == (out.result == '0)))
        else begin
            $error("z_flag disagrees with the result");
            fail_count++;
        end

    branch_result_zero: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out.b_flag && (out.result != '0)))
        else begin
            $error("branch taken with a nonzero result");
            fail_count++;
        end

endmodule

bind exec_stage exec_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out       (out)
);

`default_nettype wire

// ==== testbench/tb_exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module tb_exec_stage;

    localparam int CLK_NS = 4;
    localparam int W      = `EXEC_XLEN;

    // Expected flags as {z, c, o, b, illegal}
    localparam logic [4:0] F_NONE = 5'b00000;
    localparam logic [4:0] F_Z    = 5'b10000;
    localparam logic [4:0] F_C    = 5'b01000;
    localparam logic [4:0] F_O    = 5'b00100;
    localparam logic [4:0] F_B    = 5'b00010;
    localparam logic [4:0] F_I    = 5'b00001;

    typedef struct packed {
        logic [W-1:0] instr;
        logic [W-1:0] op1;
        logic [W-1:0] op2;
        logic [W-1:0] result;
        logic [4:0]   flags;
    } vector_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    mips_isa_pkg::instr_u   instr;
    logic [W-1:0]           op1;
    logic [W-1:0]           op2;
    logic                   out_valid;
    exec_pkg::exec_result_t out;
    vector_t                vectors[$];
    logic                   table_ready = 1'b0;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_stage u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .op1       (op1),
        .op2       (op2),
        .out_valid (out_valid),
        .out       (out)
    );

    function automatic logic [W-1:0] r_word(input logic [5:0] funct, input logic [4:0] shamt);
        return {6'h00, 15'd0, shamt, funct};    // rs, rt, rd unused here
    endfunction

    function automatic logic [W-1:0] i_word(input logic [5:0] opcode, input logic [15:0] imm);
        return {opcode, 10'd0, imm};            // rt = 0 also selects bltz
    endfunction

    task automatic add_row(input logic [W-1:0] word, input logic [W-1:0] a,
                           input logic [W-1:0] b, input logic [W-1:0] res,
                           input logic [4:0] flags);
        vectors.push_back('{word, a, b, res, flags});
    endtask

    task automatic build_table();
        // Arithmetic, carry and overflow
        add_row(r_word(mips_isa_pkg::fn_add, 5'd0), 32'h7fffffff, 32'h1, 32'h80000000, F_O);
        add_row(r_word(mips_isa_pkg::fn_add, 5'd0), 32'hffffffff, 32'h1, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_sub, 5'd0), 32'h80000000, 32'h1, 32'h7fffffff, F_O);
        add_row(r_word(mips_isa_pkg::fn_addu, 5'd0), 32'hffffffff, 32'h1, 32'h0, F_Z | F_C);
        add_row(r_word(mips_isa_pkg::fn_subu, 5'd0), 32'h1, 32'h2, 32'hffffffff, F_C);
        add_row(r_word(mips_isa_pkg::fn_subu, 5'd0), 32'h2, 32'h1, 32'h1, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_addi, 16'hfffb), 32'h5, 32'h0, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_addi, 16'hffff), 32'h80000000, 32'h0, 32'h7fffffff, F_O);
        add_row(i_word(mips_isa_pkg::opc_addiu, 16'hfff0), 32'h20, 32'h0, 32'h10, F_C);
        // Logic, immediates zero extended
        add_row(r_word(mips_isa_pkg::fn_and, 5'd0), 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_or, 5'd0), 32'hf0f0f0f0, 32'h0f0f0000, 32'hfffff0f0, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_xor, 5'd0), 32'haaaaaaaa, 32'haaaaaaaa, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_nor, 5'd0), 32'h12340000, 32'h5678, 32'hedcba987, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_andi, 16'h8001), 32'hffffffff, 32'h0, 32'h8001, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_ori, 16'h8000), 32'h00ff0000, 32'h0, 32'h00ff8000, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_xori, 16'hffff), 32'hffffffff, 32'h0, 32'hffff0000, F_NONE);
        // Shifts, variable forms take op1[4:0]
        add_row(r_word(mips_isa_pkg::fn_sll, 5'd4), 32'h0, 32'h80000001, 32'h10, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_srl, 5'd4), 32'h0, 32'h80000000, 32'h08000000, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_sra, 5'd4), 32'h0, 32'h80000000, 32'hf8000000, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_sllv, 5'd0), 32'h24, 32'h1, 32'h10, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_srlv, 5'd0), 32'h3f, 32'h80000000, 32'h1, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_srav, 5'd0), 32'h28, 32'h80000000, 32'hff800000, F_NONE);
        // Signed versus unsigned order
        add_row(r_word(mips_isa_pkg::fn_slt, 5'd0), 32'hffffffff, 32'h1, 32'h1, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_sltu, 5'd0), 32'hffffffff, 32'h1, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_slti, 16'hffff), 32'h1, 32'h0, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_sltiu, 16'hffff), 32'h00010000, 32'h0, 32'h1, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_slti, 16'h0001), 32'hffffffff, 32'h0, 32'h1, F_NONE);
        add_row(i_word(mips_isa_pkg::opc_sltiu, 16'h0001), 32'hffffffff, 32'h0, 32'h0, F_Z);
        // Branches always give a zero result
        add_row(i_word(mips_isa_pkg::opc_beq, 16'h0), 32'h5, 32'h5, 32'h0, F_Z | F_B);
        add_row(i_word(mips_isa_pkg::opc_beq, 16'h0), 32'h5, 32'h6, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_bne, 16'h0), 32'h5, 32'h6, 32'h0, F_Z | F_B);
        add_row(i_word(mips_isa_pkg::opc_regimm, 16'h0), 32'hffffffff, 32'h0, 32'h0, F_Z | F_B);
        add_row(i_word(mips_isa_pkg::opc_regimm, 16'h0), 32'h0, 32'h0, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_blez, 16'h0), 32'h0, 32'h0, 32'h0, F_Z | F_B);
        add_row(i_word(mips_isa_pkg::opc_blez, 16'h0), 32'h1, 32'h0, 32'h0, F_Z);
        add_row(i_word(mips_isa_pkg::opc_bgtz, 16'h0), 32'h1, 32'h0, 32'h0, F_Z | F_B);
        add_row(i_word(mips_isa_pkg::opc_bgtz, 16'h0), 32'h0, 32'h0, 32'h0, F_Z);
        // HI/LO, reads right after the writer
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'h0, F_Z);    // Reset value
        add_row(r_word(mips_isa_pkg::fn_mult, 5'd0), 32'hfffffffe, 32'h3, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'hffffffff, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mflo, 5'd0), 32'h0, 32'h0, 32'hfffffffa, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_multu, 5'd0), 32'hfffffffe, 32'h3, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'h2, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mflo, 5'd0), 32'h0, 32'h0, 32'hfffffffa, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_div, 5'd0), 32'hfffffff9, 32'h2, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'hffffffff, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mflo, 5'd0), 32'h0, 32'h0, 32'hfffffffd, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_divu, 5'd0), 32'h12345678, 32'h0, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'h12345678, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mflo, 5'd0), 32'h0, 32'h0, 32'hffffffff, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mthi, 5'd0), 32'hcafef00d, 32'h0, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mtlo, 5'd0), 32'h0badc0de, 32'h0, 32'h0, F_Z);
        add_row(r_word(mips_isa_pkg::fn_mfhi, 5'd0), 32'h0, 32'h0, 32'hcafef00d, F_NONE);
        add_row(r_word(mips_isa_pkg::fn_mflo, 5'd0), 32'h0, 32'h0, 32'h0badc0de, F_NONE);
        // Unused opcode and funct, then a normal op
        add_row(32'hfc000000, 32'h1, 32'h1, 32'h0, F_Z | F_I);
        add_row(r_word(6'h01, 5'd0), 32'h1, 32'h1, 32'h0, F_Z | F_I);
        add_row(r_word(mips_isa_pkg::fn_addu, 5'd0), 32'h1, 32'h1, 32'h2, F_NONE);
    endtask

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        if (got !== exp) begin
            $display("error: time %0t, %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_row(input int idx);
        vector_t v;
        v = vectors[idx];
        check_value("out_valid", W'(out_valid), W'(1'b1));
        check_value("out.result", out.result, v.result);
        check_value("out.z_flag", W'(out.z_flag), W'(v.flags[4]));
        check_value("out.c_flag", W'(out.c_flag), W'(v.flags[3]));
        check_value("out.o_flag", W'(out.o_flag), W'(v.flags[2]));
        check_value("out.b_flag", W'(out.b_flag), W'(v.flags[1]));
        check_value("out.illegal", W'(out.illegal), W'(v.flags[0]));
    endtask

    // Stop at the first failure of a bound assertion
    always @(u_dut.u_assert.fail_count) begin
        if (u_dut.u_assert.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "bound assertion failed");
        end
    end

    initial begin
        wait (table_ready);
        #((vectors.size() + 20) * CLK_NS);      // Rows plus reset and drain margin
        $display("timeout: the execute stage did not finish the test table in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        in_valid <= 1'b0;
        instr    <= '0;
        op1      <= '0;
        op2      <= '0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i <= vectors.size(); i++) begin
            @(posedge clk);
            if (i < vectors.size()) begin       // Back to back issue
                in_valid <= 1'b1;
                instr    <= vectors[i].instr;
                op1      <= vectors[i].op1;
                op2      <= vectors[i].op2;
            end else begin
                in_valid <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);                 // Previous row's output is settled
                check_row(i - 1);
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_value("out_valid", W'(out_valid), '0);    // Pipeline drained
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/exec_pkg.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/hilo_unit.sv
rtl/exec_stage.sv
testbench/tb_clock_gen.sv
testbench/exec_assertions.sv
testbench/tb_exec_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_exec_stage
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
RUN_FLAGS  := +verilator+error+limit+100
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
